/* dmg_clk_pkg.sv */
// Clock and reset shared definitions
package dmg_clk_pkg;

	// Widths with a meaning
	typedef logic [7:0] addr_t;	// Offset in the high I/O page
	typedef logic [7:0] data_t;	// Bus data byte
	typedef logic [15:0] div_t;	// Divider count

	// Machine-cycle phases
	typedef enum logic [1:0] {
		T1,
		T2,
		T3,
		T4
	} phase_t;

	// Bus request, held stable while valid is high
	typedef struct packed {
		logic  write;
		addr_t addr;
		data_t wdata;
	} bus_req_t;

	// Bus response
	typedef struct packed {
		data_t rdata;
	} bus_rsp_t;

	// Register map
	localparam addr_t DIV_ADDR  = 8'h04;
	localparam addr_t HRAM_BASE = 8'h80;
	localparam addr_t HRAM_LAST = 8'hFE;
	localparam data_t OPEN_BUS  = 8'hFF;	// Unmapped read value

	// Divider bit whose carry wakes the reset sequencer
	localparam int WAKE_BIT = 5;	// Real hardware sits much higher (16 Hz)

endpackage

/* src/clk_phase_gen.sv */
// Machine-cycle phase generator
`timescale 1ns/1ps

module clk_phase_gen (
	input  logic clk,
	input  logic reset,
	input  logic clk_ena,
	output logic adr_clk,
	output logic data_clk,
	output logic latch_clk,
	output logic inc_clk,
	output logic main_clk
);
	import dmg_clk_pkg::*;

	phase_t phase;
	phase_t phase_next;

	always_comb begin
		case (phase)
			T1: phase_next = T2;
			T2: phase_next = T3;
			T3: phase_next = T4;
			default: phase_next = T1;	// T4 wraps
		endcase
	end

	// Phase only moves on enabled cycles
	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= T1;
		end else if (clk_ena) begin
			phase <= phase_next;
		end
	end

	// Strobe decode, all low while the oscillator is gated
	always_comb begin
		adr_clk   = 1'b0;
		data_clk  = 1'b0;
		latch_clk = 1'b0;
		inc_clk   = 1'b0;
		main_clk  = 1'b0;
		if (clk_ena) begin
			adr_clk   = (phase == T1);
			data_clk  = (phase == T2) || (phase == T3);
			latch_clk = (phase == T3);
			inc_clk   = (phase == T4);
			main_clk  = (phase == T4);	// Machine-cycle boundary
		end
	end

endmodule

/* src/reset_seq.sv */
// CPU reset sequencer
`timescale 1ns/1ps

module reset_seq (
	input  logic clk,
	input  logic reset,
	input  logic clk_ena,
	input  logic osc_ena,
	input  logic main_clk,
	input  logic wake,
	output logic osc_stable,
	output logic cpu_reset
);

	logic armed;	// Stable and a wake pulse has been seen

	// Oscillator stable flag
	always_ff @(posedge clk) begin
		if (reset || !osc_ena) begin
			osc_stable <= 1'b0;
		end else if (clk_ena) begin
			osc_stable <= 1'b1;
		end
	end

	// Arm on the first divider wake after stability
	always_ff @(posedge clk) begin
		if (reset || !osc_ena) begin
			armed <= 1'b0;
		end else if (osc_stable && wake) begin
			armed <= 1'b1;
		end
	end

	// Release and reassert only on a machine-cycle boundary
	always_ff @(posedge clk) begin
		if (reset) begin
			cpu_reset <= 1'b1;
		end else if (main_clk) begin
			cpu_reset <= !armed;
		end
	end

endmodule

/* src/div_timer.sv */
// Machine-cycle divider register
`timescale 1ns/1ps

module div_timer (
	input  logic                clk,
	input  logic                reset,
	input  logic                main_clk,
	input  logic                div_clear,
	output dmg_clk_pkg::data_t  div_value,
	output logic                wake
);
	import dmg_clk_pkg::*;

	div_t count;
	logic low_full;	// Low bits about to roll over

	assign low_full = &count[WAKE_BIT:0];

	// Counts machine cycles, a bus write clears the lot
	always_ff @(posedge clk) begin
		if (reset || div_clear) begin
			count <= '0;
		end else if (main_clk) begin
			count <= count + 1'b1;
		end
	end

	// Carry out of the wake bit, one cycle wide
	always_ff @(posedge clk) begin
		if (reset) begin
			wake <= 1'b0;
		end else begin
			wake <= main_clk && low_full && !div_clear;
		end
	end

	assign div_value = count[15:8];	// Only the upper byte is visible

endmodule

/* src/mcycle_bus.sv */
// Machine-cycle bus unit
`timescale 1ns/1ps

module mcycle_bus (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  cpu_reset,
	input  logic                  adr_clk,
	input  logic                  latch_clk,
	input  logic                  main_clk,
	input  logic                  req_valid,
	output logic                  req_ready,
	input  dmg_clk_pkg::bus_req_t req,
	output logic                  rsp_valid,
	input  logic                  rsp_ready,
	output dmg_clk_pkg::bus_rsp_t rsp,
	input  dmg_clk_pkg::data_t    div_value,
	output logic                  div_clear
);
	import dmg_clk_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		WAIT_T1,
		ACTIVE,
		RESPOND
	} bus_state_t;

	bus_state_t state;
	bus_req_t   req_q;	// Access in flight
	data_t      rdata_q;
	data_t      rd_mux;
	logic       hram_hit;
	logic [6:0] hram_idx;
	logic       do_latch;

	data_t hram [0:HRAM_LAST - HRAM_BASE];	// 127 bytes

	assign req_ready = (state == IDLE) && !cpu_reset;
	assign rsp_valid = (state == RESPOND);
	assign rsp.rdata = rdata_q;

	// Address decode
	assign hram_hit = (req_q.addr >= HRAM_BASE) && (req_q.addr <= HRAM_LAST);
	assign hram_idx = 7'(req_q.addr - HRAM_BASE);
	assign do_latch = (state == ACTIVE) && latch_clk;

	always_comb begin
		if (hram_hit) begin
			rd_mux = hram[hram_idx];
		end else if (req_q.addr == DIV_ADDR) begin
			rd_mux = div_value;
		end else begin
			rd_mux = OPEN_BUS;
		end
	end

	assign div_clear = do_latch && req_q.write && (req_q.addr == DIV_ADDR);

	// Access sequencing, one machine cycle per access
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: if (req_valid && req_ready) begin
					state <= adr_clk ? ACTIVE : WAIT_T1;	// Already in T1
				end
				WAIT_T1: if (adr_clk) state <= ACTIVE;
				ACTIVE: if (main_clk) state <= RESPOND;
				default: if (rsp_ready) state <= IDLE;	// Held under back-pressure
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid && req_ready) begin
			req_q <= req;
		end
	end

	// Data moves at the latch strobe in T3
	always_ff @(posedge clk) begin
		if (do_latch) begin
			rdata_q <= rd_mux;	// Don't care on writes
			if (req_q.write && hram_hit) begin
				hram[hram_idx] <= req_q.wdata;
			end
		end
	end

endmodule

/* src/clk_reset_top.sv */
// Clock and reset block top level
`timescale 1ns/1ps

module clk_reset_top (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  clk_ena,
	input  logic                  osc_ena,
	output logic                  adr_clk,
	output logic                  data_clk,
	output logic                  latch_clk,
	output logic                  inc_clk,
	output logic                  main_clk,
	output logic                  osc_stable,
	output logic                  cpu_reset,
	input  logic                  req_valid,
	output logic                  req_ready,
	input  dmg_clk_pkg::bus_req_t req,
	output logic                  rsp_valid,
	input  logic                  rsp_ready,
	output dmg_clk_pkg::bus_rsp_t rsp
);
	import dmg_clk_pkg::*;

	logic  wake;	// Divider carry to the sequencer
	logic  div_clear;
	data_t div_value;

	clk_phase_gen clk_phase_gen_i (
		.clk       (clk),
		.reset     (reset),
		.clk_ena   (clk_ena),
		.adr_clk   (adr_clk),
		.data_clk  (data_clk),
		.latch_clk (latch_clk),
		.inc_clk   (inc_clk),
		.main_clk  (main_clk)
	);

	reset_seq reset_seq_i (
		.clk        (clk),
		.reset      (reset),
		.clk_ena    (clk_ena),
		.osc_ena    (osc_ena),
		.main_clk   (main_clk),
		.wake       (wake),
		.osc_stable (osc_stable),
		.cpu_reset  (cpu_reset)
	);

	div_timer div_timer_i (
		.clk       (clk),
		.reset     (reset),
		.main_clk  (main_clk),
		.div_clear (div_clear),
		.div_value (div_value),
		.wake      (wake)
	);

	mcycle_bus mcycle_bus_i (
		.clk       (clk),
		.reset     (reset),
		.cpu_reset (cpu_reset),
		.adr_clk   (adr_clk),
		.latch_clk (latch_clk),
		.main_clk  (main_clk),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req       (req),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp       (rsp),
		.div_value (div_value),
		.div_clear (div_clear)
	);

endmodule

/* bench/clk_reset_tb.sv */
// Clock and reset block testbench
`timescale 1ns/1ps

module clk_reset_tb;
	import dmg_clk_pkg::*;

	localparam int TIMEOUT_CYCLES = 6000;	// Two releases and about 190 accesses plus the long waits

	logic clk = 1'b0;
	logic reset, clk_ena, osc_ena;
	logic adr_clk, data_clk, latch_clk, inc_clk, main_clk;
	logic osc_stable, cpu_reset;
	logic req_valid, req_ready, rsp_valid, rsp_ready;
	bus_req_t req;
	bus_rsp_t rsp;

	// Reference model
	phase_t model_phase;
	logic [4:0] strobes;
	logic [4:0] exp_strobes;
	div_t div_count;	// main_clk pulses since the last clear
	data_t shadow [0:126];
	bus_req_t acc;	// Access waiting for its latch strobe
	logic acc_busy, acc_t1, exp_write, osc_seen;
	data_t exp_rdata;
	int since_accept, stable_wait, errors, accesses;
	int cycles = 0;

	always #4 clk = ~clk;

	clk_reset_top clk_reset_top_i (.*);

	function automatic logic [4:0] phase_strobes(phase_t p, logic ena);
		logic [4:0] s;
		s = 5'b00000;
		if (ena) begin
			case (p)
				T1: s = 5'b10000;	// Address
				T2: s = 5'b01000;
				T3: s = 5'b01100;	// Data and latch
				default: s = 5'b00011;	// Increment and main
			endcase
		end
		return s;
	endfunction

	function automatic data_t expected_read(addr_t a);
		if (a >= HRAM_BASE && a <= HRAM_LAST) begin
			return shadow[7'(a - HRAM_BASE)];
		end else if (a == DIV_ADDR) begin
			return div_count[15:8];
		end
		return OPEN_BUS;
	endfunction

	assign strobes = {adr_clk, data_clk, latch_clk, inc_clk, main_clk};
	assign exp_strobes = phase_strobes(model_phase, clk_ena);

	always @(posedge clk) begin
		if (reset) begin
			model_phase <= T1;
			div_count <= '0;
			acc_busy <= 1'b0;
			acc_t1 <= 1'b0;
			exp_write <= 1'b1;	// No read to compare yet
			osc_seen <= 1'b0;
			since_accept <= 0;
			stable_wait <= 0;
		end else begin
			if (clk_ena) model_phase <= phase_t'(2'(model_phase + 1));
			if (osc_ena) osc_seen <= 1'b1;
			since_accept <= (req_valid && req_ready) ? 1 : since_accept + 1;
			stable_wait <= (osc_stable && cpu_reset) ? stable_wait + 1 : 0;
			if (main_clk) div_count <= div_count + 16'd1;
			if (req_valid && req_ready) begin
				acc_busy <= 1'b1;
				acc <= req;
				acc_t1 <= adr_clk;
			end else if (acc_busy && !acc_t1) begin
				acc_t1 <= adr_clk;	// First T1 after acceptance
			end else if (acc_busy && latch_clk) begin
				acc_busy <= 1'b0;
				exp_write <= acc.write;
				exp_rdata <= expected_read(acc.addr);
				if (acc.write && acc.addr == DIV_ADDR) div_count <= '0;
				if (acc.write && acc.addr >= HRAM_BASE && acc.addr <= HRAM_LAST) begin
					shadow[7'(acc.addr - HRAM_BASE)] <= acc.wdata;
				end
			end
		end
	end

	task automatic report_mismatch(string name, int got, int expected);
		errors++;
		$display("mismatch at %0t: %s = %0h, expected %0h", $time, name, got, expected);
	endtask

	task automatic report_range(string name, int got, int lo, int hi);
		errors++;
		$display("mismatch at %0t: %s = %0d, expected %0d to %0d", $time, name, got, lo, hi);
	endtask

	task automatic report_failure(string what);
		errors++;
		$display("error at %0t: %s", $time, what);
	endtask

	strobe_check: assert property (@(posedge clk) disable iff (reset) strobes == exp_strobes)
		else report_mismatch("strobes", $sampled(strobes), $sampled(exp_strobes));
	hold_check: assert property (@(posedge clk) disable iff (reset)
		!osc_seen |-> cpu_reset && !req_ready)
		else report_failure("CPU reset or bus released before the oscillator was enabled");
	stable_set_check: assert property (@(posedge clk) disable iff (reset)
		osc_ena && clk_ena |=> osc_stable) else report_mismatch("osc_stable", 0, 1);
	stable_clr_check: assert property (@(posedge clk) disable iff (reset)
		!osc_ena |=> !osc_stable) else report_mismatch("osc_stable", 1, 0);
	release_edge_check: assert property (@(posedge clk) disable iff (reset)
		$fell(cpu_reset) |-> $past(main_clk))
		else report_failure("cpu_reset fell away from a machine-cycle boundary");
	release_time_check: assert property (@(posedge clk) disable iff (reset) stable_wait <= 260)
		else report_range("cycles from osc_stable to release", $sampled(stable_wait), 0, 260);
	reassert_check: assert property (@(posedge clk) disable iff (reset)
		main_clk && !osc_stable |=> cpu_reset) else report_mismatch("cpu_reset", 0, 1);
	ready_check: assert property (@(posedge clk) disable iff (reset)
		cpu_reset || rsp_valid |-> !req_ready)
		else report_failure("req_ready high during CPU reset or a pending response");
	rdata_check: assert property (@(posedge clk) disable iff (reset)
		rsp_valid && !exp_write |-> rsp.rdata == exp_rdata)
		else report_mismatch("rsp.rdata", $sampled(rsp.rdata), $sampled(exp_rdata));
	latency_check: assert property (@(posedge clk) disable iff (reset)
		$rose(rsp_valid) |-> since_accept >= 4 && since_accept <= 7)
		else report_range("response latency", $sampled(since_accept), 4, 7);
	boundary_check: assert property (@(posedge clk) disable iff (reset)
		$rose(rsp_valid) |-> $past(main_clk))
		else report_failure("response did not follow a main_clk pulse");
	backpressure_check: assert property (@(posedge clk) disable iff (reset)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
		else report_failure("response dropped or changed while stalled");

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic wait_cycles(int n);
		repeat (n) step();
	endtask

	// One access with random response stalls
	task automatic bus_access(logic write, addr_t addr, data_t wdata);
		logic done;
		done = 1'b0;
		req = '{write: write, addr: addr, wdata: wdata};
		req_valid = 1'b1;
		while (!req_ready) step();
		step();
		req_valid = 1'b0;
		while (!done) begin
			rsp_ready = ($urandom % 3) != 0;
			done = rsp_valid && rsp_ready;
			step();
		end
		rsp_ready = 1'b0;
		accesses++;
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("%0d errors after %0d bus accesses", errors + 1, accesses);
			$display("Test failures found");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'h7456_f50a));
		errors = 0;
		accesses = 0;
		reset = 1'b1;
		clk_ena = 1'b0;
		osc_ena = 1'b0;
		req_valid = 1'b0;
		req = '0;
		rsp_ready = 1'b0;
		wait_cycles(2);
		reset = 1'b0;
		clk_ena = 1'b1;
		repeat (3) begin	// Oscillator gated in random stretches
			wait_cycles(6 + $urandom % 8);
			clk_ena = 1'b0;
			wait_cycles(3 + $urandom % 10);
			clk_ena = 1'b1;
		end
		wait_cycles(300);	// A divider wake passes while the oscillator is still off
		osc_ena = 1'b1;
		while (cpu_reset) step();
		for (int i = 0; i < 127; i++) begin
			bus_access(1'b1, addr_t'(HRAM_BASE + i), data_t'($urandom));
		end
		repeat (50) bus_access(1'b0, addr_t'(HRAM_BASE + $urandom % 127), 8'h00);
		bus_access(1'b0, 8'hFF, 8'h00);
		repeat (4) bus_access(1'b0, addr_t'(8'h10 + $urandom % 8'h60), 8'h00);
		bus_access(1'b1, DIV_ADDR, 8'h5A);	// Clears the divider
		repeat (3) begin
			wait_cycles($urandom % 40);
			bus_access(1'b0, DIV_ADDR, 8'h00);
		end
		wait_cycles(1100);	// Upper byte ticks after 256 machine cycles
		bus_access(1'b0, DIV_ADDR, 8'h00);
		osc_ena = 1'b0;
		while (!cpu_reset) step();
		wait_cycles(10);
		osc_ena = 1'b1;
		while (cpu_reset) step();
		bus_access(1'b0, addr_t'(HRAM_BASE + $urandom % 127), 8'h00);
		wait_cycles(8);
		$display("%0d errors after %0d bus accesses", errors, accesses);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* clk_reset_top.f */
dmg_clk_pkg.sv
src/clk_phase_gen.sv
src/reset_seq.sv
src/div_timer.sv
src/mcycle_bus.sv
src/clk_reset_top.sv
bench/clk_reset_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the clock and reset testbench with Verilator

LOG=sim.log
FAIL_MSG="Test failures found"

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module clk_reset_tb -f clk_reset_top.f -o clk_reset_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/clk_reset_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "$FAIL_MSG" "$LOG"; then
	echo "Simulation reported failures, see $LOG"
	exit 1
fi

echo "Simulation clean, see $LOG"
exit 0
